// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/line_refill.sv
      - hdl/icache.sv
      - hdl/fetch_unit.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/mem_model.sv
      - bench/fetch_checker.sv
      - bench/fetch_tb.sv

// ==== all.f ====
hdl/fetch_pkg.sv
hdl/line_refill.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;      // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== bench/fetch_checker.sv ====
`timescale 1ns/1ns

module fetch_checker (
    input logic                    clock,
    input logic                    reset,
    input logic                    stall_i,
    input fetch_pkg::fetch_out_t   fetch_o,
    input fetch_pkg::mem_rd_req_t  mem_req_o,
    input fetch_pkg::mem_rd_resp_t mem_resp_i
);

    int failures = 0;

    // Output frozen across a stalled edge
    assert property (@(posedge clock) disable iff (reset)
        stall_i |=> $stable(fetch_o))
        else begin
            $error("fetch output changed while stalled");
            failures++;
        end

    assert property (@(posedge clock) disable iff (reset)
        mem_req_o.valid && !mem_resp_i.ready |=> mem_req_o.valid && $stable(mem_req_o.addr))
        else begin
            $error("memory request dropped before the first beat");
            failures++;
        end

    assert property (@(posedge clock) disable iff (reset)
        mem_req_o.valid |-> mem_req_o.addr[fetch_pkg::offset_bits+1:0] == '0
                            && mem_req_o.len == fetch_pkg::burst_len)
        else begin
            $error("memory request not line aligned or wrong length");
            failures++;
        end

endmodule

bind fetch_unit fetch_checker u_checker (.*);

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

    localparam int total_fetches     = 110;
    localparam int worst_miss_cycles = 60;
    localparam int timeout_ns        = total_fetches * worst_miss_cycles * 4 + 200;

    logic                    clock;
    logic                    reset;
    fetch_pkg::redirect_t    redirect;
    logic                    stall;
    fetch_pkg::fetch_out_t   fetch;
    fetch_pkg::mem_rd_req_t  mem_req;
    fetch_pkg::mem_rd_resp_t mem_resp;

    fetch_pkg::fetch_out_t   got [$];
    int                      snap;
    logic                    stall_done;

    clock_gen clkgen (.clock(clock), .reset(reset));

    mem_model mem (.clock(clock), .reset(reset), .req_i(mem_req), .resp_o(mem_resp));

    fetch_top uut (
        .clock      (clock),
        .reset      (reset),
        .redirect_i (redirect),
        .stall_i    (stall),
        .fetch_o    (fetch),
        .mem_req_o  (mem_req),
        .mem_resp_i (mem_resp)
    );

    // An instruction is taken on an edge where it is valid and not stalled
    always @(posedge clock) begin
        if (!reset && fetch.valid && !stall) begin
            got.push_back(fetch);
        end
    end

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", test, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic next_fetch(output fetch_pkg::fetch_out_t item);
        while (got.size() == 0) begin
            @(negedge clock);
        end
        item = got.pop_front();
    endtask

    task automatic jump_to(input logic [31:0] pc);
        @(negedge clock);
        redirect.valid = 1'b1;
        redirect.pc    = pc;
        @(negedge clock);
        redirect.valid = 1'b0;
        got.delete();
        snap = mem.bursts.size();
    endtask

    // Bursts since the last redirect that start inside [lo, hi)
    function automatic int bursts_in(input logic [31:0] lo, input logic [31:0] hi);
        int n;
        n = 0;
        for (int i = snap; i < mem.bursts.size(); i++) begin
            if (mem.bursts[i].addr >= lo && mem.bursts[i].addr < hi) begin
                n++;
            end
        end
        return n;
    endfunction

    // Every burst since the last redirect starts on a line with len 3
    task automatic check_bursts(input string test);
        for (int i = snap; i < mem.bursts.size(); i++) begin
            check_value({test, " alignment"}, 0, mem.bursts[i].addr[3:0]);
            check_value({test, " length"}, 3, mem.bursts[i].len);
        end
    endtask

    task automatic run_stream(input string test, input logic [31:0] start, input int count);
        fetch_pkg::fetch_out_t item;
        for (int i = 0; i < count; i++) begin
            next_fetch(item);
            check_value(test, start + 32'(4 * i), item.pc);
            check_value(test, model_word(start + 32'(4 * i)), item.inst);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        run_stream("reset", fetch_pkg::reset_pc, 1);
    endtask

    task automatic test_sequential();
        jump_to(32'h3000_0100);
        run_stream("sequential", 32'h3000_0100, 32);
        check_value("sequential bursts", 8, bursts_in(32'h3000_0100, 32'h3000_0180));
        check_bursts("sequential burst");
    endtask

    task automatic test_hit_reuse();
        jump_to(32'h3000_0100);
        run_stream("hit reuse", 32'h3000_0100, 32);
        check_value("hit reuse bursts", 0, bursts_in(32'h3000_0100, 32'h3000_0180));
    endtask

    task automatic test_redirect();
        fetch_pkg::fetch_out_t item;
        jump_to(32'h3000_0400);
        while (!(mem_req.valid && mem_req.addr == 32'h3000_0400)) begin
            @(negedge clock);
        end
        jump_to(32'h3000_0800);         // Lands while the 0x400 line is in flight
        next_fetch(item);
        check_value("redirect target", 32'h3000_0800, item.pc);
        check_value("redirect target", model_word(32'h3000_0800), item.inst);
        run_stream("redirect", 32'h3000_0804, 4);
    endtask

    task automatic test_stall();
        jump_to(32'h3000_0200);
        stall_done = 1'b0;
        fork
            begin
                run_stream("stall", 32'h3000_0200, 24);
                stall_done = 1'b1;
            end
            begin
                while (!stall_done) begin
                    @(negedge clock);
                    stall = 1'b1;
                    repeat (1 + $urandom % 6) @(negedge clock);
                    stall = 1'b0;
                    repeat ($urandom % 3) @(negedge clock);
                end
                stall = 1'b0;
            end
        join
    endtask

    task automatic test_conflict();
        logic [31:0] addr;
        for (int i = 0; i < 6; i++) begin
            addr = (i % 2 == 0) ? 32'h3000_1040 : 32'h3000_2040;
            jump_to(addr);
            run_stream("conflict", addr, 1);
            check_value("conflict bursts", 1, bursts_in(addr, addr + 1));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(22938));
        redirect.valid = 1'b0;
        redirect.pc    = '0;
        stall          = 1'b0;
        snap           = 0;
        stall_done     = 1'b0;
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end
        @(negedge clock);
        test_reset();
        test_sequential();
        test_hit_reuse();
        test_redirect();
        test_stall();
        test_conflict();
        if (uut.u_fetch.u_checker.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (uut.u_fetch.u_checker.failures != 0);
        $display("A handshake or stall assertion in the fetch checker failed");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the fetch unit stopped delivering instructions");
        $display("Checks failed");
        $fatal(1);
    end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ns

module mem_model (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::mem_rd_req_t  req_i,
    output fetch_pkg::mem_rd_resp_t resp_o
);

    fetch_pkg::mem_rd_req_t     bursts [$];      // Every burst request seen
    logic                       active;
    logic [fetch_pkg::xlen-1:0] base;
    int                         beat;

    initial begin
        void'($urandom(22938));
        resp_o.ready = 1'b0;
        resp_o.data  = '0;
        resp_o.last  = 1'b0;
        active       = 1'b0;
        base         = '0;
        beat         = 0;
        forever begin
            @(negedge clock);
            resp_o.ready = 1'b0;
            resp_o.last  = 1'b0;
            if (reset) begin
                active = 1'b0;
            end else begin
                if (!active && req_i.valid) begin
                    active = 1'b1;
                    base   = req_i.addr;
                    beat   = 0;
                    bursts.push_back(req_i);
                end
                // Roughly one cycle in four is a gap
                if (active && ($urandom % 4) != 0) begin
                    resp_o.ready = 1'b1;
                    resp_o.data  = (base + 32'(4 * beat)) ^ 32'hA5A5_0000;
                    resp_o.last  = (beat == fetch_pkg::line_words - 1);
                    if (resp_o.last) begin
                        active = 1'b0;
                    end
                    beat = beat + 1;
                end
            end
        end
    end

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int              xlen        = 32;
    localparam logic [xlen-1:0] reset_pc    = 32'h3000_0000;
    localparam int              line_words  = 4;
    localparam logic [1:0]      burst_len   = 2'(line_words - 1); // AXI len code
    localparam int              set_count   = 16;
    localparam int              tag_bits    = 24;
    localparam int              index_bits  = 4;
    localparam int              offset_bits = 2;

    // Cache view of a fetch address
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] word;
        logic [1:0]             byte_sel;
    } addr_fields_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        addr_fields_t    f;
    } fetch_addr_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_out_t;

    typedef struct packed {
        logic        valid;
        fetch_addr_u addr;
    } cache_req_t;

    typedef struct packed {
        logic            ready;     // One-cycle pulse
        logic [xlen-1:0] data;
    } cache_resp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [1:0]      len;
    } mem_rd_req_t;

    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] data;
        logic            last;
    } mem_rd_resp_t;

endpackage

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic                    clock,
    input  logic                    reset,

    // Core side
    input  fetch_pkg::redirect_t    redirect_i,
    input  logic                    stall_i,
    output fetch_pkg::fetch_out_t   fetch_o,

    // Memory side
    output fetch_pkg::mem_rd_req_t  mem_req_o,
    input  fetch_pkg::mem_rd_resp_t mem_resp_i
);

    fetch_unit u_fetch (
        .clock      (clock),
        .reset      (reset),
        .redirect_i (redirect_i),
        .stall_i    (stall_i),
        .fetch_o    (fetch_o),
        .mem_req_o  (mem_req_o),
        .mem_resp_i (mem_resp_i)
    );

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::redirect_t    redirect_i,
    input  logic                    stall_i,
    output fetch_pkg::fetch_out_t   fetch_o,
    output fetch_pkg::mem_rd_req_t  mem_req_o,
    input  fetch_pkg::mem_rd_resp_t mem_resp_i
);

    logic [fetch_pkg::xlen-1:0] pc_q;
    logic [fetch_pkg::xlen-1:0] next_pc;
    fetch_pkg::cache_req_t      req_q;
    fetch_pkg::cache_resp_t     resp;
    fetch_pkg::fetch_out_t      out_q;
    fetch_pkg::fetch_out_t      skid_q;
    logic                       stale_q;
    logic                       issue;
    logic                       take;

    assign next_pc = redirect_i.valid ? redirect_i.pc : pc_q;

    // New request only once the previous word has left the skid
    assign issue = !req_q.valid && !skid_q.valid && !stall_i;

    // Response still belongs to the current path
    assign take = resp.ready && !stale_q && !redirect_i.valid;

    assign fetch_o = out_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC, request and output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q         <= fetch_pkg::reset_pc;
            req_q.valid  <= 1'b0;
            stale_q      <= 1'b0;
            out_q.valid  <= 1'b0;
            skid_q.valid <= 1'b0;
        end else begin
            pc_q <= issue ? next_pc + 4 : next_pc;

            if (issue) begin
                req_q.valid    <= 1'b1;
                req_q.addr.raw <= next_pc;
            end else if (resp.ready) begin
                req_q.valid <= 1'b0;          // Low for one cycle after the pulse
            end

            if (resp.ready) begin
                stale_q <= 1'b0;
            end else if (redirect_i.valid && req_q.valid) begin
                stale_q <= 1'b1;              // Drop whatever comes back
            end

            if (stall_i) begin
                // Output frozen, late word parks in the skid
                skid_q.valid <= take || (skid_q.valid && !redirect_i.valid);
                if (take) begin
                    skid_q.pc   <= req_q.addr.raw;
                    skid_q.inst <= resp.data;
                end
            end else begin
                out_q.valid  <= !redirect_i.valid && (skid_q.valid || take);
                skid_q.valid <= 1'b0;
                if (skid_q.valid) begin
                    out_q.pc   <= skid_q.pc;
                    out_q.inst <= skid_q.inst;
                end else if (take) begin
                    out_q.pc   <= req_q.addr.raw;
                    out_q.inst <= resp.data;
                end
            end
        end
    end

    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .req_i      (req_q),
        .resp_o     (resp),
        .mem_req_o  (mem_req_o),
        .mem_resp_i (mem_resp_i)
    );

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ns

module icache (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::cache_req_t   req_i,
    output fetch_pkg::cache_resp_t  resp_o,
    output fetch_pkg::mem_rd_req_t  mem_req_o,
    input  fetch_pkg::mem_rd_resp_t mem_resp_i
);

    typedef enum logic [1:0] {
        c_idle,
        c_lookup,
        c_refill
    } state_t;

    state_t                 state_q;
    fetch_pkg::fetch_addr_u addr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [fetch_pkg::xlen-1:0]     data_q [fetch_pkg::set_count][fetch_pkg::line_words];
    logic [fetch_pkg::tag_bits-1:0] tag_q  [fetch_pkg::set_count];
    logic [fetch_pkg::set_count-1:0] valid_q;

    logic                              hit;
    logic                              miss;
    logic                              fill_we;
    logic [fetch_pkg::offset_bits-1:0] fill_word;
    logic [fetch_pkg::xlen-1:0]        fill_data;
    logic                              fill_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hit  = (state_q == c_lookup)
                  && valid_q[addr_q.f.index]
                  && (tag_q[addr_q.f.index] == addr_q.f.tag);
    assign miss = (state_q == c_lookup) && !hit;

    assign resp_o.ready = hit;
    assign resp_o.data  = data_q[addr_q.f.index][addr_q.f.word];

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= c_idle;
        end else begin
            case (state_q)
                c_idle: begin
                    if (req_i.valid) begin
                        state_q <= c_lookup;
                    end
                end
                c_lookup: begin
                    state_q <= hit ? c_idle : c_refill;
                end
                c_refill: begin
                    if (fill_done) begin
                        state_q <= c_lookup; // Hits on the fresh line
                    end
                end
                default: state_q <= c_idle;
            endcase
        end
    end

    // Request address held for lookup and refill
    always_ff @(posedge clock) begin
        if (state_q == c_idle && req_i.valid) begin
            addr_q <= req_i.addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[addr_q.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_we) begin
            data_q[addr_q.f.index][fill_word] <= fill_data;
        end
        if (fill_done) begin
            tag_q[addr_q.f.index] <= addr_q.f.tag;
        end
    end

    line_refill u_refill (
        .clock       (clock),
        .reset       (reset),
        .miss_i      (miss),
        .miss_addr_i (addr_q),
        .mem_req_o   (mem_req_o),
        .mem_resp_i  (mem_resp_i),
        .fill_we_o   (fill_we),
        .fill_word_o (fill_word),
        .fill_data_o (fill_data),
        .done_o      (fill_done)
    );

endmodule

// ==== hdl/line_refill.sv ====
`timescale 1ns/1ns

module line_refill (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              miss_i,
    input  fetch_pkg::fetch_addr_u            miss_addr_i,
    output fetch_pkg::mem_rd_req_t            mem_req_o,
    input  fetch_pkg::mem_rd_resp_t           mem_resp_i,
    output logic                              fill_we_o,
    output logic [fetch_pkg::offset_bits-1:0] fill_word_o,
    output logic [fetch_pkg::xlen-1:0]        fill_data_o,
    output logic                              done_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_beats
    } state_t;

    state_t                            state_q;
    fetch_pkg::fetch_addr_u            line_q;
    fetch_pkg::fetch_addr_u            line_addr;
    logic [fetch_pkg::offset_bits-1:0] beat_cnt_q;
    logic                              addr_phase;
    logic                              beat;

    // Line base of the missing address
    always_comb begin
        line_addr            = miss_addr_i;
        line_addr.f.word     = '0;
        line_addr.f.byte_sel = '0;
    end

    // Address phase opens together with the miss strobe
    assign addr_phase = (state_q == st_addr) || (state_q == st_idle && miss_i);
    assign beat       = mem_resp_i.ready && (addr_phase || state_q == st_beats);

    assign mem_req_o.valid = addr_phase;
    assign mem_req_o.addr  = (state_q == st_idle) ? line_addr.raw : line_q.raw;
    assign mem_req_o.len   = fetch_pkg::burst_len;

    assign fill_we_o   = beat;
    assign fill_word_o = beat_cnt_q;        // Beats arrive in word order
    assign fill_data_o = mem_resp_i.data;
    assign done_o      = beat && mem_resp_i.last;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= st_idle;
            beat_cnt_q <= '0;
        end else if (done_o) begin
            state_q    <= st_idle;
            beat_cnt_q <= '0;
        end else if (beat) begin
            state_q    <= st_beats;
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end else if (addr_phase) begin
            state_q <= st_addr;      // Hold valid until the first beat
        end
    end

    // Address kept for the rest of the burst
    always_ff @(posedge clock) begin
        if (state_q == st_idle && miss_i) begin
            line_q <= line_addr;
        end
    end

endmodule
